// File: gbc_bus_pkg.sv
`default_nettype none

package gbc_bus_pkg;

   // ==================================================
   // bus widths
   // ==================================================
   localparam int addr_w = 16;
   localparam int data_w = 8;
   localparam int tgt_w  = 2;

   // one bus address, seen whole or as page and offset bytes
   // part[1] is the page, part[0] the offset within it
   typedef union packed {
      logic [addr_w-1:0]  raw;
      logic [1:0][7:0]    part;
   } bus_addr_u;

   // target codes
   localparam logic [tgt_w-1:0] tgt_none  = 2'd0;
   localparam logic [tgt_w-1:0] tgt_wram  = 2'd1;
   localparam logic [tgt_w-1:0] tgt_ioreg = 2'd2;

   // ==================================================
   // memory map
   // ==================================================
   localparam logic [addr_w-1:0] wram_base        = 16'hC000;
   localparam logic [addr_w-1:0] wram_switch_base = 16'hD000;
   localparam logic [addr_w-1:0] echo_base        = 16'hE000;
   localparam logic [addr_w-1:0] echo_end         = 16'hFDFF;
   localparam logic [7:0]        io_page          = 8'hFF;
   // first offset past the io registers, hram starts here
   localparam logic [7:0]        io_limit         = 8'h80;

   // work ram offset width, C000-DFFF
   localparam int wram_idx_w = $clog2(int'(echo_base - wram_base));

   localparam logic [data_w-1:0] unmapped_data = 8'hFF;

endpackage

`default_nettype wire

// File: gbc_ioreg_pkg.sv
`default_nettype none

package gbc_ioreg_pkg;

   // ==================================================
   // offsets within the FF page
   // ==================================================
   localparam logic [7:0] off_sb   = 8'h01;
   localparam logic [7:0] off_sc   = 8'h02;
   localparam logic [7:0] off_rp   = 8'h56;
   localparam logic [7:0] off_ff6c = 8'h6C;
   localparam logic [7:0] off_svbk = 8'h70;
   localparam logic [7:0] off_ff72 = 8'h72;
   localparam logic [7:0] off_ff73 = 8'h73;
   localparam logic [7:0] off_ff74 = 8'h74;
   localparam logic [7:0] off_ff75 = 8'h75;
   // read only pair
   localparam logic [7:0] off_ff76 = 8'h76;
   localparam logic [7:0] off_ff77 = 8'h77;

   // ==================================================
   // reset bytes
   // ==================================================
   localparam logic [7:0] sb_reset   = 8'h00;
   localparam logic [7:0] sc_reset   = 8'h7C;
   localparam logic [7:0] rp_reset   = 8'hFD;
   localparam logic [7:0] ff6c_reset = 8'hFE;
   localparam logic [7:0] ff72_reset = 8'h00;
   localparam logic [7:0] ff73_reset = 8'h00;
   localparam logic [7:0] ff74_reset = 8'h00;
   localparam logic [7:0] ff75_reset = 8'h8F;
   localparam logic [7:0] ff76_reset = 8'h00;
   localparam logic [7:0] ff77_reset = 8'h00;

   // ==================================================
   // SVBK layout
   // ==================================================
   localparam int         svbk_bits = 3;
   // upper bits always read as ones
   localparam logic [7:0] svbk_fill = 8'hF8;

endpackage

`default_nettype wire

// File: mem_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded request between decode and access stages
interface mem_stage_if;

   logic                                valid;
   logic                                ready;
   gbc_bus_pkg::bus_addr_u              addr;
   logic                                we;
   logic [gbc_bus_pkg::data_w-1:0]      wdata;
   logic [gbc_bus_pkg::tgt_w-1:0]       tgt;

   modport src (
      output valid,
      output addr,
      output we,
      output wdata,
      output tgt,
      input  ready
   );

   modport dst (
      input  valid,
      input  addr,
      input  we,
      input  wdata,
      input  tgt,
      output ready
   );

endinterface

`default_nettype wire

// File: mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none

// access stage to one storage block, rdata is combinational
interface mem_port_if #(
   parameter int idx_w = 8
);

   logic                                wr_en;
   logic [idx_w-1:0]                    index;
   logic [gbc_bus_pkg::data_w-1:0]      wdata;
   logic [gbc_bus_pkg::data_w-1:0]      rdata;

   modport ctrl (
      output wr_en,
      output index,
      output wdata,
      input  rdata
   );

   modport mem (
      input  wr_en,
      input  index,
      input  wdata,
      output rdata
   );

endinterface

`default_nettype wire

// File: addr_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module addr_decode_stage (
   input  wire                               clock,
   input  wire                               arst_n,
   input  wire                               req_valid,
   output logic                              req_ready,
   input  gbc_bus_pkg::bus_addr_u            req_addr,
   input  wire                               req_we,
   input  wire [gbc_bus_pkg::data_w-1:0]     req_wdata,
   mem_stage_if.src                          dn
);

   gbc_bus_pkg::bus_addr_u              addr_next;
   logic [gbc_bus_pkg::tgt_w-1:0]       tgt_next;

   // ==================================================
   // address classification
   // ==================================================
   always_comb begin
      addr_next = req_addr;
      tgt_next  = gbc_bus_pkg::tgt_none;
      if (req_addr.raw >= gbc_bus_pkg::wram_base &&
          req_addr.raw <= gbc_bus_pkg::echo_end) begin
         tgt_next = gbc_bus_pkg::tgt_wram;
         // echo folds back onto C000-DDFF
         if (req_addr.raw >= gbc_bus_pkg::echo_base) begin
            addr_next.raw = req_addr.raw -
                            (gbc_bus_pkg::echo_base - gbc_bus_pkg::wram_base);
         end
      end else if (req_addr.part[1] == gbc_bus_pkg::io_page &&
                   req_addr.part[0] < gbc_bus_pkg::io_limit) begin
         tgt_next = gbc_bus_pkg::tgt_ioreg;
      end
   end

   // take a new request when empty or draining
   assign req_ready = !dn.valid || dn.ready;

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         dn.valid <= 1'b0;
      end else if (req_ready) begin
         dn.valid <= req_valid;
      end
   end

   // payload
   always_ff @(posedge clock) begin
      if (req_valid && req_ready) begin
         dn.addr  <= addr_next;
         dn.we    <= req_we;
         dn.wdata <= req_wdata;
         dn.tgt   <= tgt_next;
      end
   end

endmodule

`default_nettype wire

// File: mem_access_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access_stage (
   input  wire                               clock,
   input  wire                               arst_n,
   mem_stage_if.dst                          up,
   mem_port_if.ctrl                          wram,
   mem_port_if.ctrl                          ioreg,
   output logic                              out_valid,
   input  wire                               out_ready,
   output logic [gbc_bus_pkg::data_w-1:0]    out_rdata
);

   logic                                accept;
   logic [gbc_bus_pkg::data_w-1:0]      rd_sel;

   // held while a read result waits downstream
   assign up.ready = !out_valid || out_ready;
   assign accept   = up.valid && up.ready;

   // ==================================================
   // storage ports
   // ==================================================
   // writes land on the same edge the request is taken
   assign wram.wr_en  = accept && up.we && (up.tgt == gbc_bus_pkg::tgt_wram);
   assign wram.index  = up.addr.raw[gbc_bus_pkg::wram_idx_w-1:0];
   assign wram.wdata  = up.wdata;

   assign ioreg.wr_en = accept && up.we && (up.tgt == gbc_bus_pkg::tgt_ioreg);
   assign ioreg.index = up.addr.part[0];
   assign ioreg.wdata = up.wdata;

   // read data select
   always_comb begin
      case (up.tgt)
         gbc_bus_pkg::tgt_wram:  rd_sel = wram.rdata;
         gbc_bus_pkg::tgt_ioreg: rd_sel = ioreg.rdata;
         default:                rd_sel = gbc_bus_pkg::unmapped_data;
      endcase
   end

   // ==================================================
   // result register
   // ==================================================
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else if (up.ready) begin
         // writes give no response
         out_valid <= up.valid && !up.we;
      end
   end

   always_ff @(posedge clock) begin
      if (accept && !up.we) begin
         out_rdata <= rd_sel;
      end
   end

endmodule

`default_nettype wire

// File: wram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module wram_bank (
   input  wire                                   clock,
   input  wire                                   arst_n,
   mem_port_if.mem                               port,
   input  wire [gbc_ioreg_pkg::svbk_bits-1:0]    svbk
);

   // 4 KiB per bank
   localparam int bank_bytes = int'(gbc_bus_pkg::wram_switch_base - gbc_bus_pkg::wram_base);
   localparam int bank_off_w = $clog2(bank_bytes);
   localparam int bank_count = 2 ** gbc_ioreg_pkg::svbk_bits;
   localparam int phys_w     = gbc_ioreg_pkg::svbk_bits + bank_off_w;

   logic [gbc_bus_pkg::data_w-1:0]      mem [bank_count*bank_bytes];
   logic [gbc_ioreg_pkg::svbk_bits-1:0] bank;
   logic [phys_w-1:0]                   phys;

   // ==================================================
   // bank select
   // ==================================================
   always_comb begin
      if (!port.index[bank_off_w]) begin
         // C000-CFFF is always bank 0
         bank = '0;
      end else if (svbk == '0) begin
         // SVBK of 0 maps to bank 1
         bank = gbc_ioreg_pkg::svbk_bits'(1);
      end else begin
         bank = svbk;
      end
   end

   assign phys = {bank, port.index[bank_off_w-1:0]};

   // no writes while reset is held
   always_ff @(posedge clock) begin
      if (arst_n && port.wr_en) begin
         mem[phys] <= port.wdata;
      end
   end

   assign port.rdata = mem[phys];

endmodule

`default_nettype wire

// File: io_register_file.sv
`timescale 1ns/1ps
`default_nettype none

module io_register_file (
   input  wire                                   clock,
   input  wire                                   arst_n,
   mem_port_if.mem                               port,
   output logic [gbc_ioreg_pkg::svbk_bits-1:0]   svbk
);

   logic [7:0]                          sb_q;
   logic [7:0]                          sc_q;
   logic [7:0]                          rp_q;
   logic [7:0]                          ff6c_q;
   logic [7:0]                          ff72_q;
   logic [7:0]                          ff73_q;
   logic [7:0]                          ff74_q;
   logic [7:0]                          ff75_q;
   logic [gbc_bus_pkg::data_w-1:0]      svbk_rd;

   // ==================================================
   // writable registers
   // ==================================================
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         sb_q   <= gbc_ioreg_pkg::sb_reset;
         sc_q   <= gbc_ioreg_pkg::sc_reset;
         rp_q   <= gbc_ioreg_pkg::rp_reset;
         ff6c_q <= gbc_ioreg_pkg::ff6c_reset;
         ff72_q <= gbc_ioreg_pkg::ff72_reset;
         ff73_q <= gbc_ioreg_pkg::ff73_reset;
         ff74_q <= gbc_ioreg_pkg::ff74_reset;
         ff75_q <= gbc_ioreg_pkg::ff75_reset;
         svbk   <= '0;
      end else if (port.wr_en) begin
         case (port.index)
            gbc_ioreg_pkg::off_sb:   sb_q   <= port.wdata;
            gbc_ioreg_pkg::off_sc:   sc_q   <= port.wdata;
            gbc_ioreg_pkg::off_rp:   rp_q   <= port.wdata;
            gbc_ioreg_pkg::off_ff6c: ff6c_q <= port.wdata;
            gbc_ioreg_pkg::off_ff72: ff72_q <= port.wdata;
            gbc_ioreg_pkg::off_ff73: ff73_q <= port.wdata;
            gbc_ioreg_pkg::off_ff74: ff74_q <= port.wdata;
            gbc_ioreg_pkg::off_ff75: ff75_q <= port.wdata;
            // only the bank number is kept
            gbc_ioreg_pkg::off_svbk: svbk   <= port.wdata[gbc_ioreg_pkg::svbk_bits-1:0];
            default: ;
         endcase
      end
   end

   assign svbk_rd = {{(gbc_bus_pkg::data_w - gbc_ioreg_pkg::svbk_bits){1'b0}}, svbk}
                    | gbc_ioreg_pkg::svbk_fill;

   // ==================================================
   // read mux
   // ==================================================
   always_comb begin
      case (port.index)
         gbc_ioreg_pkg::off_sb:   port.rdata = sb_q;
         gbc_ioreg_pkg::off_sc:   port.rdata = sc_q;
         gbc_ioreg_pkg::off_rp:   port.rdata = rp_q;
         gbc_ioreg_pkg::off_ff6c: port.rdata = ff6c_q;
         gbc_ioreg_pkg::off_svbk: port.rdata = svbk_rd;
         gbc_ioreg_pkg::off_ff72: port.rdata = ff72_q;
         gbc_ioreg_pkg::off_ff73: port.rdata = ff73_q;
         gbc_ioreg_pkg::off_ff74: port.rdata = ff74_q;
         gbc_ioreg_pkg::off_ff75: port.rdata = ff75_q;
         // read-only, writes never reach these
         gbc_ioreg_pkg::off_ff76: port.rdata = gbc_ioreg_pkg::ff76_reset;
         gbc_ioreg_pkg::off_ff77: port.rdata = gbc_ioreg_pkg::ff77_reset;
         default:                 port.rdata = gbc_bus_pkg::unmapped_data;
      endcase
   end

endmodule

`default_nettype wire

// File: read_response_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module read_response_fifo #(
   parameter int depth = 2
) (
   input  wire                               clock,
   input  wire                               arst_n,
   input  wire                               in_valid,
   output logic                              in_ready,
   input  wire [gbc_bus_pkg::data_w-1:0]     in_rdata,
   output logic                              rsp_valid,
   input  wire                               rsp_ready,
   output logic [gbc_bus_pkg::data_w-1:0]    rsp_rdata
);

   localparam int ptr_w = $clog2(depth);
   localparam int cnt_w = $clog2(depth + 1);
   localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);
   localparam logic [cnt_w-1:0] full_cnt = cnt_w'(depth);

   logic [gbc_bus_pkg::data_w-1:0]      mem [depth];
   logic [ptr_w-1:0]                    wr_ptr;
   logic [ptr_w-1:0]                    rd_ptr;
   logic [cnt_w-1:0]                    count;
   logic                                push;
   logic                                load;

   assign in_ready = (count != full_cnt);
   assign push     = in_valid && in_ready;
   // head moves to the output register when it is free or draining
   assign load     = (count != '0) && (!rsp_valid || rsp_ready);

   // ==================================================
   // pointers and fill count
   // ==================================================
   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         rsp_valid <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
         end
         if (load) begin
            rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, load})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (load) begin
            rsp_valid <= 1'b1;
         end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
         end
      end
   end

   // storage and output byte
   always_ff @(posedge clock) begin
      if (push) begin
         mem[wr_ptr] <= in_rdata;
      end
      if (load) begin
         rsp_rdata <= mem[rd_ptr];
      end
   end

endmodule

`default_nettype wire

// File: gbc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module gbc_mem_top #(
   parameter int rsp_depth = 2
) (
   input  wire                               clock,
   input  wire                               arst_n,
   input  wire                               req_valid,
   output wire                               req_ready,
   input  wire [gbc_bus_pkg::addr_w-1:0]     req_addr,
   input  wire                               req_we,
   input  wire [gbc_bus_pkg::data_w-1:0]     req_wdata,
   output wire                               rsp_valid,
   input  wire                               rsp_ready,
   output wire [gbc_bus_pkg::data_w-1:0]     rsp_rdata
);

   wire [gbc_ioreg_pkg::svbk_bits-1:0]  svbk;
   wire                                 out_valid;
   wire                                 out_ready;
   wire [gbc_bus_pkg::data_w-1:0]       out_rdata;

   // ==================================================
   // stage links
   // ==================================================
   mem_stage_if stage_bus ();
   mem_port_if #(.idx_w(gbc_bus_pkg::wram_idx_w)) wram_port ();
   mem_port_if #(.idx_w(8)) ioreg_port ();

   addr_decode_stage i_decode (
      .clock     (clock),
      .arst_n    (arst_n),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_addr  (req_addr),
      .req_we    (req_we),
      .req_wdata (req_wdata),
      .dn        (stage_bus.src)
   );

   mem_access_stage i_access (
      .clock     (clock),
      .arst_n    (arst_n),
      .up        (stage_bus.dst),
      .wram      (wram_port.ctrl),
      .ioreg     (ioreg_port.ctrl),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_rdata (out_rdata)
   );

   wram_bank i_wram (
      .clock  (clock),
      .arst_n (arst_n),
      .port   (wram_port.mem),
      .svbk   (svbk)
   );

   io_register_file i_ioreg (
      .clock  (clock),
      .arst_n (arst_n),
      .port   (ioreg_port.mem),
      .svbk   (svbk)
   );

   read_response_fifo #(.depth(rsp_depth)) i_rsp_fifo (
      .clock     (clock),
      .arst_n    (arst_n),
      .in_valid  (out_valid),
      .in_ready  (out_ready),
      .in_rdata  (out_rdata),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_rdata (rsp_rdata)
   );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// free running testbench clock
module tb_clock_gen #(
   parameter int period = 20
) (
   output logic clock
);

   initial begin
      clock = 1'b0;
      forever begin
         #(period / 2);
         clock = ~clock;
      end
   end

endmodule

`default_nettype wire

// File: tb_gbc_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gbc_mem;

   localparam int wait_limit = 200;
   localparam int random_ops = 3000;
   // one cycle more than a read needs to reach rsp_valid
   localparam int drain_idle = 4;

   logic                                clock;
   logic                                arst_n;
   logic                                req_valid;
   wire                                 req_ready;
   logic [gbc_bus_pkg::addr_w-1:0]      req_addr;
   logic                                req_we;
   logic [gbc_bus_pkg::data_w-1:0]      req_wdata;
   wire                                 rsp_valid;
   logic                                rsp_ready;
   wire  [gbc_bus_pkg::data_w-1:0]      rsp_rdata;

   logic [31:0]                         rng;
   logic [31:0]                         stall_rng;
   logic                                stall_on;
   int                                  read_count;
   int                                  rsp_count;

   // reference model
   logic [7:0]                          wram_model [32768];
   bit                                  wram_known [32768];
   logic [7:0]                          io_model [256];
   logic [2:0]                          svbk_model;
   logic [gbc_bus_pkg::data_w-1:0]      exp_q [$];

   tb_clock_gen #(.period(20)) i_clock_gen (.clock(clock));

   gbc_mem_top #(.rsp_depth(2)) i_gbc_mem_top (
      .clock     (clock),
      .arst_n    (arst_n),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_addr  (req_addr),
      .req_we    (req_we),
      .req_wdata (req_wdata),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_rdata (rsp_rdata)
   );

   // ==================================================
   // random numbers and model rules
   // ==================================================
   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic bit is_wram(input logic [15:0] addr);
      return addr >= 16'hC000 && addr <= 16'hFDFF;
   endfunction

   function automatic bit is_io(input logic [15:0] addr);
      return addr[15:8] == 8'hFF && addr[7:0] < 8'h80;
   endfunction

   function automatic bit is_plain_reg(input logic [7:0] off);
      case (off)
         8'h01, 8'h02, 8'h56, 8'h6C, 8'h72, 8'h73, 8'h74, 8'h75: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   // listed registers of the FF page
   function automatic logic [7:0] listed_offset(input int idx);
      case (idx)
         0: return 8'h01;
         1: return 8'h02;
         2: return 8'h56;
         3: return 8'h6C;
         4: return 8'h70;
         5: return 8'h72;
         6: return 8'h73;
         7: return 8'h74;
         8: return 8'h75;
         9: return 8'h76;
         default: return 8'h77;
      endcase
   endfunction

   // echo fold then bank 0 or the switched bank
   function automatic logic [14:0] wram_phys(input logic [15:0] addr);
      logic [15:0] folded;
      logic [12:0] off;
      logic [2:0]  bank;
      folded = (addr >= 16'hE000) ? addr - 16'h2000 : addr;
      off    = 13'(folded - 16'hC000);
      if (!off[12]) begin
         bank = 3'd0;
      end else if (svbk_model == 3'd0) begin
         bank = 3'd1;
      end else begin
         bank = svbk_model;
      end
      return {bank, off[11:0]};
   endfunction

   function automatic logic [7:0] model_read(input logic [15:0] addr);
      if (is_wram(addr)) return wram_model[wram_phys(addr)];
      if (!is_io(addr)) return 8'hFF;
      if (is_plain_reg(addr[7:0])) return io_model[addr[7:0]];
      if (addr[7:0] == 8'h70) return 8'hF8 | {5'b00000, svbk_model};
      if (addr[7:0] == 8'h76 || addr[7:0] == 8'h77) return 8'h00;
      return 8'hFF;
   endfunction

   task automatic model_write(input logic [15:0] addr, input logic [7:0] data);
      logic [14:0] phys;
      if (is_wram(addr)) begin
         phys = wram_phys(addr);
         wram_model[phys] = data;
         wram_known[phys] = 1'b1;
      end else if (is_io(addr) && is_plain_reg(addr[7:0])) begin
         io_model[addr[7:0]] = data;
      end else if (is_io(addr) && addr[7:0] == 8'h70) begin
         svbk_model = data[2:0];
      end
   endtask

   task automatic model_reset();
      for (int i = 0; i < 32768; i++) begin
         wram_known[i] = 1'b0;
      end
      io_model[8'h01] = 8'h00;
      io_model[8'h02] = 8'h7C;
      io_model[8'h56] = 8'hFD;
      io_model[8'h6C] = 8'hFE;
      io_model[8'h72] = 8'h00;
      io_model[8'h73] = 8'h00;
      io_model[8'h74] = 8'h00;
      io_model[8'h75] = 8'h8F;
      svbk_model      = 3'd0;
   endtask

   function automatic logic [15:0] pick_wram_addr(input logic [31:0] r);
      logic [15:0] page;
      case (r[31:30])
         2'd0:    page = 16'hC000;
         2'd1:    page = 16'hD000;
         2'd2:    page = 16'hE000;
         default: page = 16'hF000;
      endcase
      return page | {10'd0, r[29:24]};
   endfunction

   function automatic logic [15:0] pick_unmapped_addr(input logic [31:0] r);
      case (r[31:30])
         2'd0:    return {8'hFE, r[23:16]};
         2'd1:    return {8'hFF, 1'b1, r[22:16]};
         default: return r[29:14] % 16'hC000;
      endcase
   endfunction

   // ==================================================
   // checks
   // ==================================================
   task automatic stop_with_error(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_rdata(input logic [gbc_bus_pkg::data_w-1:0] expected,
                              input logic [gbc_bus_pkg::data_w-1:0] actual);
      if (actual !== expected) begin
         stop_with_error($sformatf("MISMATCH at %0t: rsp_rdata expected %02h got %02h",
                                   $time, expected, actual));
      end
   endtask

   task automatic check_count(input int expected, input int actual);
      if (actual != expected) begin
         stop_with_error($sformatf("MISMATCH at %0t: response count expected %0d got %0d",
                                   $time, expected, actual));
      end
   endtask

   task automatic check_latency(input int expected, input int actual);
      if (actual != expected) begin
         stop_with_error($sformatf("MISMATCH at %0t: rsp_valid latency expected %0d got %0d",
                                   $time, expected, actual));
      end
   endtask

   task automatic check_level(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         stop_with_error($sformatf("MISMATCH at %0t: %s expected %0b got %0b",
                                   $time, name, expected, actual));
      end
   endtask

   // ==================================================
   // request driver and response monitor
   // ==================================================
   // starts 2 ns after a rising edge and returns 2 ns after acceptance
   task automatic issue(input logic we, input logic [15:0] addr, input logic [7:0] data);
      int waited;
      req_valid = 1'b1;
      req_we    = we;
      req_addr  = addr;
      req_wdata = data;
      waited    = 0;
      @(negedge clock);
      while (!req_ready) begin
         waited++;
         if (waited > wait_limit) begin
            stop_with_error("request was never accepted, req_ready stayed low");
         end
         @(negedge clock);
      end
      @(posedge clock);
      if (we) begin
         model_write(addr, data);
      end else begin
         exp_q.push_back(model_read(addr));
         read_count++;
      end
      #2;
      req_valid = 1'b0;
   endtask

   // pipeline counts as empty once rsp_valid stays low long enough
   task automatic wait_drain();
      int waited;
      int idle;
      waited = 0;
      idle   = 0;
      while (idle < drain_idle) begin
         @(negedge clock);
         idle = rsp_valid ? 0 : idle + 1;
         waited++;
         if (waited > wait_limit) begin
            stop_with_error("responses kept coming and the pipeline never went idle");
         end
      end
      check_count(read_count, rsp_count);
      @(posedge clock);
      #2;
   endtask

   task automatic measure_read_latency(input logic [15:0] addr);
      int cycles;
      issue(1'b0, addr, 8'h00);
      cycles = 0;
      @(negedge clock);
      while (!rsp_valid) begin
         cycles++;
         if (cycles > wait_limit) begin
            stop_with_error("rsp_valid never rose after a single read");
         end
         @(negedge clock);
      end
      check_latency(3, cycles);
      @(posedge clock);
      #2;
   endtask

   // transfer happens on the next rising edge
   always @(negedge clock) begin
      if (arst_n && rsp_valid && rsp_ready) begin
         if (exp_q.size() == 0) begin
            stop_with_error("response arrived with no read outstanding");
         end else begin
            check_rdata(exp_q.pop_front(), rsp_rdata);
            rsp_count++;
         end
      end
   end

   always @(posedge clock) begin
      #2;
      if (stall_on) begin
         stall_rng = lcg_step(stall_rng);
         rsp_ready = stall_rng[31];
      end else begin
         rsp_ready = 1'b1;
      end
   end

   // ==================================================
   // test sequence
   // ==================================================
   initial begin
      logic [15:0] addr;
      req_valid  = 1'b0;
      req_addr   = '0;
      req_we     = 1'b0;
      req_wdata  = '0;
      rsp_ready  = 1'b1;
      arst_n     = 1'b0;
      stall_on   = 1'b0;
      rng        = 32'h6f5fed27;
      stall_rng  = ~32'h6f5fed27;
      read_count = 0;
      rsp_count  = 0;
      model_reset();
      repeat (8) @(posedge clock);
      #2;
      arst_n = 1'b1;
      check_level("req_ready", 1'b1, req_ready);
      check_level("rsp_valid", 1'b0, rsp_valid);

      // idle pipeline latency then reset bytes
      measure_read_latency(16'hFF02);
      for (int i = 0; i < 11; i++) begin
         issue(1'b0, {8'hFF, listed_offset(i)}, 8'h00);
      end
      wait_drain();

      // unmapped space reads FF and ignores writes
      for (int i = 0; i < 200; i++) begin
         rng  = lcg_step(rng);
         addr = pick_unmapped_addr(rng);
         rng  = lcg_step(rng);
         issue(rng[31], addr, rng[23:16]);
         issue(1'b0, addr, 8'h00);
      end
      for (int i = 0; i < 11; i++) begin
         issue(1'b0, {8'hFF, listed_offset(i)}, 8'h00);
      end
      wait_drain();

      // work ram traffic with bank switches and output stalls
      stall_on = 1'b1;
      issue(1'b1, 16'hFF70, 8'h00);
      for (int i = 0; i < random_ops; i++) begin
         rng = lcg_step(rng);
         if (rng[31:28] == 4'h0) begin
            rng = lcg_step(rng);
            issue(1'b1, 16'hFF70, rng[31:24]);
         end else if (rng[31:28] == 4'h1) begin
            issue(1'b0, 16'hFF70, 8'h00);
         end else begin
            rng  = lcg_step(rng);
            addr = pick_wram_addr(rng);
            rng  = lcg_step(rng);
            // unwritten locations get a write first
            if (rng[23] || !wram_known[wram_phys(addr)]) begin
               issue(1'b1, addr, rng[31:24]);
            end else begin
               issue(1'b0, addr, 8'h00);
            end
         end
      end

      // register write and read back with FF76 and FF77 staying zero
      for (int i = 0; i < 11; i++) begin
         rng = lcg_step(rng);
         issue(1'b1, {8'hFF, listed_offset(i)}, rng[31:24]);
         issue(1'b0, {8'hFF, listed_offset(i)}, 8'h00);
      end
      wait_drain();
      stall_on = 1'b0;

      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
gbc_bus_pkg.sv
gbc_ioreg_pkg.sv
mem_stage_if.sv
mem_port_if.sv
addr_decode_stage.sv
mem_access_stage.sv
wram_bank.sv
io_register_file.sv
read_response_fifo.sv
gbc_mem_top.sv
tb_clock_gen.sv
tb_gbc_mem.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module tb_gbc_mem -f list.f || exit 1
./obj_dir/Vtb_gbc_mem > sim.log 2>&1
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
